//--- axi4s_pkg.sv
package axi4s_pkg;

    // ========================================================================
    // Stream geometry
    // ========================================================================

    // Bytes carried by one beat
    localparam int DATA_BYTE_WID = 8;

    // Sideband widths
    localparam int TID_WID   = 4;
    localparam int TDEST_WID = 4;
    localparam int TUSER_WID = 8;

    // Byte limit and byte counter width
    localparam int LEN_WID = 16;

    // Enough bits to count 0 up to DATA_BYTE_WID kept lanes
    localparam int CNT_WID = $clog2(DATA_BYTE_WID + 1);

    // ========================================================================
    // Types
    // ========================================================================

    // Per-packet byte limit, zero disables truncation
    typedef logic [LEN_WID-1:0] trunc_len_t;

    // Payload of one beat, handshake kept outside
    typedef struct packed {
        logic [DATA_BYTE_WID-1:0][7:0] tdata;
        logic [DATA_BYTE_WID-1:0]      tkeep;
        logic                          tlast;
        logic [TID_WID-1:0]            tid;
        logic [TDEST_WID-1:0]          tdest;
        logic [TUSER_WID-1:0]          tuser;
    } axi4s_beat_t;

    // ========================================================================
    // Helpers
    // ========================================================================

    // Number of kept lanes in a beat
    function automatic logic [CNT_WID-1:0] keep_count(logic [DATA_BYTE_WID-1:0] keep);
        logic [CNT_WID-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            n = n + CNT_WID'(keep[i]);
        end
        return n;
    endfunction

    // Force data of every unkept lane to zero
    function automatic axi4s_beat_t zero_unkept(axi4s_beat_t beat);
        axi4s_beat_t res;
        res = beat;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            if (!beat.tkeep[i]) begin
                res.tdata[i] = 8'h00;
            end
        end
        return res;
    endfunction

endpackage

//--- axi4s_trunc.sv
`timescale 1ns/1ps

module axi4s_trunc #(
    parameter int BIGENDIAN = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi4s_pkg::trunc_len_t  trunc_len,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  axi4s_pkg::axi4s_beat_t in_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output axi4s_pkg::axi4s_beat_t out_beat
);
    import axi4s_pkg::*;

    // ========================================================================
    // Declarations
    // ========================================================================

    // Packet tracking
    logic                     init_done;
    logic                     sop;
    logic                     dropping;
    logic [LEN_WID-1:0]       byte_offset;
    trunc_len_t               limit_q;

    // Per-beat decode
    trunc_len_t               cur_limit;
    logic [CNT_WID-1:0]       beat_bytes;
    logic [LEN_WID:0]         offset_next;
    logic [LEN_WID:0]         kept_bytes;
    logic                     limit_hit;
    logic [DATA_BYTE_WID-1:0] keep_mask;
    axi4s_beat_t              trim_beat;

    // Handshake
    logic                     accept;
    logic                     load;

    // Output stage
    logic                     stage_valid;
    axi4s_beat_t              stage_beat;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Hold off input until the first clock after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    // Tail beats need no room, kept beats need an empty or draining stage
    assign in_ready = init_done && (dropping || !stage_valid || out_ready);

    assign accept = in_valid && in_ready;

    // Only beats outside the drop state reach the stage
    assign load = accept && !dropping;

    // ========================================================================
    // Limit compare
    // ========================================================================

    // Limit is latched on the first beat, later trunc_len values ignored
    assign cur_limit = sop ? trunc_len : limit_q;

    // Bytes in this beat, keep assumed contiguous from the first lane
    assign beat_bytes = keep_count(in_beat.tkeep);

    // Packet byte count once this beat is taken
    assign offset_next = {1'b0, byte_offset} + (LEN_WID+1)'(beat_bytes);

    // Limit lands inside or at the end of this beat
    assign limit_hit = (cur_limit != '0) && (offset_next >= {1'b0, cur_limit});

    // Bytes of this beat still below the limit, valid only on a hit
    assign kept_bytes = {1'b0, cur_limit} - {1'b0, byte_offset};

    // Lane mask for the kept bytes
    always_comb begin
        keep_mask = '0;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            if (BIGENDIAN != 0) begin
                // Byte 0 of the beat in the top lane
                keep_mask[i] = kept_bytes > (LEN_WID+1)'(DATA_BYTE_WID - 1 - i);
            end else begin
                // Byte 0 of the beat in lane 0
                keep_mask[i] = kept_bytes > (LEN_WID+1)'(i);
            end
        end
    end

    // Trimmed beat, sideband passes unchanged
    always_comb begin
        trim_beat = in_beat;
        if (limit_hit) begin
            trim_beat.tkeep = in_beat.tkeep & keep_mask;
            trim_beat.tlast = 1'b1;
        end
    end

    // ========================================================================
    // Packet state
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop         <= 1'b1;
            dropping    <= 1'b0;
            byte_offset <= '0;
            limit_q     <= '0;
        end else if (accept) begin
            // Capture limit with the first beat
            if (sop) begin
                limit_q <= trunc_len;
            end
            if (in_beat.tlast) begin
                // End of packet, kept or dropped
                sop         <= 1'b1;
                dropping    <= 1'b0;
                byte_offset <= '0;
            end else if (!dropping) begin
                sop <= 1'b0;
                if (limit_hit) begin
                    // Rest of the packet is tail
                    dropping <= 1'b1;
                end else begin
                    byte_offset <= offset_next[LEN_WID-1:0];
                end
            end
        end
    end

    // ========================================================================
    // Output stage
    // ========================================================================

    // Single register, cleared whenever it drains
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            stage_beat  <= '0;
        end else if (load) begin
            stage_valid <= 1'b1;
            stage_beat  <= zero_unkept(trim_beat);
        end else if (out_ready) begin
            // Beat left or stage already empty
            stage_valid <= 1'b0;
            stage_beat  <= '0;
        end
    end

    assign out_valid = stage_valid;
    assign out_beat  = stage_beat;

endmodule

//--- axi4s_reg_slice.sv
`timescale 1ns/1ps

module axi4s_reg_slice (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  axi4s_pkg::axi4s_beat_t in_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output axi4s_pkg::axi4s_beat_t out_beat
);
    import axi4s_pkg::*;

    // ========================================================================
    // Declarations
    // ========================================================================

    // Main register feeds the output directly
    logic        main_valid;
    axi4s_beat_t main_beat;

    // Skid register catches the beat in flight when out_ready drops
    logic        skid_valid;
    axi4s_beat_t skid_beat;

    // Transfers this cycle
    logic        push;
    logic        pop;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Skid only fills behind a full main, so this means fewer than two held
    assign in_ready = !skid_valid;

    assign push = in_valid && in_ready;
    assign pop  = main_valid && out_ready;

    // ========================================================================
    // Main register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            main_beat  <= '0;
        end else if (pop) begin
            if (skid_valid) begin
                // Oldest held beat moves up
                main_valid <= 1'b1;
                main_beat  <= skid_beat;
            end else if (push) begin
                // Straight replace, full rate
                main_valid <= 1'b1;
                main_beat  <= in_beat;
            end else begin
                // Drained, clear fields
                main_valid <= 1'b0;
                main_beat  <= '0;
            end
        end else if (push && !main_valid) begin
            // Empty slice takes the beat
            main_valid <= 1'b1;
            main_beat  <= in_beat;
        end
    end

    // ========================================================================
    // Skid register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
            skid_beat  <= '0;
        end else if (pop && skid_valid) begin
            // Moved to main, vacate
            skid_valid <= 1'b0;
            skid_beat  <= '0;
        end else if (push && main_valid && !pop) begin
            // Main stalled, park the new beat
            skid_valid <= 1'b1;
            skid_beat  <= in_beat;
        end
    end

    // Outputs straight from registers
    assign out_valid = main_valid;
    assign out_beat  = main_beat;

endmodule

//--- axi4s_trunc_top.sv
`timescale 1ns/1ps

module axi4s_trunc_top #(
    parameter int BIGENDIAN = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi4s_pkg::trunc_len_t  trunc_len,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  axi4s_pkg::axi4s_beat_t in_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output axi4s_pkg::axi4s_beat_t out_beat
);
    import axi4s_pkg::*;

    // ========================================================================
    // Truncator to slice link
    // ========================================================================

    logic        mid_valid;
    logic        mid_ready;
    axi4s_beat_t mid_beat;

    // ========================================================================
    // Instances
    // ========================================================================

    // Trim, tag last and drop tail beats
    axi4s_trunc #(
        .BIGENDIAN (BIGENDIAN)
    ) axi4s_trunc_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .trunc_len (trunc_len),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_beat  (mid_beat)
    );

    // Breaks the out_ready path back to the input
    axi4s_reg_slice axi4s_reg_slice_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .in_beat   (mid_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

//--- tb_axi4s_trunc.sv
`timescale 1ns/1ps

module tb_axi4s_trunc #(
    parameter int BIGENDIAN = 0
);
    import axi4s_pkg::*;

    // ========================================================================
    // Stimulus table and DUT signals
    // ========================================================================

    localparam int NUM_ROWS = 16;

    // Pipeline holds at most three beats once input stops
    localparam int DRAIN_CYCLES = 16;

    // One packet per row
    typedef struct packed {
        logic [15:0]          pkt_len;
        trunc_len_t           limit;
        logic [TID_WID-1:0]   tid;
        logic [TDEST_WID-1:0] tdest;
        logic [TUSER_WID-1:0] tuser;
        logic                 gap;
        logic                 bp;
    } row_t;

    row_t        rows [NUM_ROWS];

    logic        clk;
    logic        rst_n;
    trunc_len_t  trunc_len;
    logic        in_valid;
    logic        in_ready;
    axi4s_beat_t in_beat;
    logic        out_valid;
    logic        out_ready;
    axi4s_beat_t out_beat;

    // Reference queue and bookkeeping
    axi4s_beat_t exp_q [$];
    logic [15:0] lfsr_state;
    logic        in_fire;
    logic        mon_armed = 1'b0;
    int          value_errors = 0;
    int          seq_errors = 0;
    int          cycle_count = 0;
    int          timeout_limit = 1000000;

    axi4s_trunc_top #(
        .BIGENDIAN (BIGENDIAN)
    ) axi4s_trunc_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .trunc_len (trunc_len),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic draw_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] draw_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], draw_bit()};
        end
        return v;
    endfunction

    function automatic trunc_len_t draw_len();
        trunc_len_t v;
        v = '0;
        for (int i = 0; i < LEN_WID; i++) begin
            v = {v[LEN_WID-2:0], draw_bit()};
        end
        return v;
    endfunction

    // Lane holding byte k of a beat
    function automatic int lane_of(input int k);
        return (BIGENDIAN != 0) ? DATA_BYTE_WID - 1 - k : k;
    endfunction

    function automatic row_t make_row(input int len, input int lim, input int tid,
                                      input int tdest, input int tuser,
                                      input int gap, input int bp);
        row_t r;
        r.pkt_len = 16'(len);
        r.limit   = LEN_WID'(lim);
        r.tid     = TID_WID'(tid);
        r.tdest   = TDEST_WID'(tdest);
        r.tuser   = TUSER_WID'(tuser);
        r.gap     = (gap != 0);
        r.bp      = (bp != 0);
        return r;
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_beat(input axi4s_beat_t exp, input axi4s_beat_t act);
        if (act.tdata !== exp.tdata) begin
            $display("[ERROR] out_beat.tdata expected %h actual %h", exp.tdata, act.tdata);
            value_errors++;
        end
        if (act.tkeep !== exp.tkeep) begin
            $display("[ERROR] out_beat.tkeep expected %h actual %h", exp.tkeep, act.tkeep);
            value_errors++;
        end
        if (act.tlast !== exp.tlast) begin
            $display("[ERROR] out_beat.tlast expected %h actual %h", exp.tlast, act.tlast);
            value_errors++;
        end
        if (act.tid !== exp.tid || act.tdest !== exp.tdest || act.tuser !== exp.tuser) begin
            $display("[ERROR] out_beat.tid/tdest/tuser expected %h/%h/%h actual %h/%h/%h",
                     exp.tid, exp.tdest, exp.tuser, act.tid, act.tdest, act.tuser);
            value_errors++;
        end
        // Dropped lanes must be blank
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            if (!act.tkeep[i] && act.tdata[i] !== 8'h00) begin
                $display("[ERROR] out_beat.tdata lane %0d unkept expected 00 actual %h",
                         i, act.tdata[i]);
                value_errors++;
            end
        end
    endtask

    task automatic check_idle(input axi4s_beat_t act);
        axi4s_beat_t zero;
        zero = '0;
        if (act !== zero) begin
            $display("[ERROR] out_beat while idle expected %h actual %h", zero, act);
            value_errors++;
        end
    endtask

    task automatic check_count();
        if (exp_q.size() != 0) begin
            $display("%0d expected output beats never appeared", exp_q.size());
            seq_errors++;
        end
    endtask

    // ========================================================================
    // Monitors
    // ========================================================================

    // Input transfer seen on the last rising edge
    always @(posedge clk) begin
        in_fire <= in_valid && in_ready;
    end

    // Output checks, skipping the first edge before reset has settled
    always @(posedge clk) begin
        axi4s_beat_t exp_beat;
        if (mon_armed) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output beat arrived with no expected beat left");
                    seq_errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_beat(exp_beat, out_beat);
                end
            end else if (!out_valid) begin
                check_idle(out_beat);
            end
        end
        mon_armed <= 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, %0d expected beats still pending",
                     cycle_count, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Driver
    // ========================================================================

    // Step to the falling edge, random out_ready about 3 of 4 cycles
    task automatic next_cycle(input logic bp);
        @(negedge clk);
        out_ready = bp ? (draw_bit() | draw_bit()) : 1'b1;
    endtask

    task automatic send_packet(input row_t r);
        logic [7:0]  pkt [$];
        axi4s_beat_t beat;
        int          len;
        int          out_len;
        int          nbeats;
        int          n;
        len     = int'(r.pkt_len);
        out_len = (r.limit == '0 || int'(r.limit) >= len) ? len : int'(r.limit);
        nbeats  = (len + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(draw_byte());
        end
        // Expected beats, first out_len bytes only
        for (int b = 0; b * DATA_BYTE_WID < out_len; b++) begin
            beat = '0;
            n = out_len - b * DATA_BYTE_WID;
            n = (n > DATA_BYTE_WID) ? DATA_BYTE_WID : n;
            for (int k = 0; k < n; k++) begin
                beat.tkeep[lane_of(k)] = 1'b1;
                beat.tdata[lane_of(k)] = pkt[b * DATA_BYTE_WID + k];
            end
            beat.tlast = ((b + 1) * DATA_BYTE_WID >= out_len);
            beat.tid   = r.tid;
            beat.tdest = r.tdest;
            beat.tuser = r.tuser;
            exp_q.push_back(beat);
        end
        // Input beats, junk in unkept lanes
        for (int b = 0; b < nbeats; b++) begin
            beat = '0;
            n = len - b * DATA_BYTE_WID;
            n = (n > DATA_BYTE_WID) ? DATA_BYTE_WID : n;
            for (int k = 0; k < DATA_BYTE_WID; k++) begin
                if (k < n) begin
                    beat.tkeep[lane_of(k)] = 1'b1;
                    beat.tdata[lane_of(k)] = pkt[b * DATA_BYTE_WID + k];
                end else begin
                    beat.tdata[lane_of(k)] = draw_byte();
                end
            end
            beat.tlast = (b == nbeats - 1);
            beat.tid   = r.tid;
            beat.tdest = r.tdest;
            beat.tuser = r.tuser;
            while (r.gap && draw_bit()) begin
                in_valid  = 1'b0;
                in_beat   = '0;
                trunc_len = draw_len();
                next_cycle(r.bp);
            end
            // Limit only valid on the first beat, noise after that
            in_valid  = 1'b1;
            in_beat   = beat;
            trunc_len = (b == 0) ? r.limit : draw_len();
            next_cycle(r.bp);
            while (!in_fire) begin
                next_cycle(r.bp);
            end
        end
    endtask

    initial begin
        int total_beats;
        int drain_wait;
        clk        = 1'b0;
        rst_n      = 1'b0;
        trunc_len  = '0;
        in_valid   = 1'b0;
        in_beat    = '0;
        out_ready  = 1'b1;
        lfsr_state = 16'd9;

        // len, limit, tid, tdest, tuser, gap, bp
        rows[0]  = make_row( 8,  0,  1,  2, 'h11, 0, 0);
        rows[1]  = make_row(20,  0,  2,  3, 'h22, 0, 0);
        rows[2]  = make_row(13, 13,  3,  4, 'h33, 0, 0);
        rows[3]  = make_row(10, 30,  4,  5, 'h44, 0, 0);
        rows[4]  = make_row(24, 16,  5,  6, 'h55, 0, 0);
        rows[5]  = make_row(30, 11,  6,  7, 'h66, 0, 0);
        rows[6]  = make_row(17,  1,  7,  8, 'h77, 0, 0);
        rows[7]  = make_row( 5,  3,  8,  9, 'h88, 0, 0);
        rows[8]  = make_row(40, 21,  9, 10, 'h99, 1, 1);
        rows[9]  = make_row(33,  0, 10, 11, 'haa, 1, 1);
        rows[10] = make_row(64,  9, 11, 12, 'hbb, 0, 1);
        rows[11] = make_row(16,  8, 12, 13, 'hcc, 1, 0);
        rows[12] = make_row( 3,  0, 13, 14, 'hdd, 1, 1);
        rows[13] = make_row(50, 50, 14, 15, 'hee, 0, 1);
        rows[14] = make_row( 1,  1, 15,  0, 'hf0, 1, 1);
        rows[15] = make_row(45, 37,  0,  1, 'h0f, 1, 1);

        total_beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_beats += (int'(rows[i].pkt_len) + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
        end
        timeout_limit = 4 * total_beats + 200;

        // Three rising edges in reset
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            send_packet(rows[i]);
        end
        in_valid  = 1'b0;
        in_beat   = '0;
        trunc_len = '0;

        // Drain the pipeline, then watch a while for stray beats
        drain_wait = 0;
        while (exp_q.size() != 0 && drain_wait < DRAIN_CYCLES) begin
            next_cycle(1'b0);
            drain_wait++;
        end
        repeat (8) next_cycle(1'b0);
        check_count();

        $display("Errors: %0d value, %0d sequence", value_errors, seq_errors);
        if (value_errors + seq_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
axi4s_pkg.sv
axi4s_trunc.sv
axi4s_reg_slice.sv
axi4s_trunc_top.sv
tb_axi4s_trunc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator once per byte order

status=0

for be in 0 1; do
    echo "=== BIGENDIAN=${be} ==="
    out=$(verilator --binary -j 0 --top-module tb_axi4s_trunc -GBIGENDIAN=${be} \
            -Mdir obj_dir_be${be} -f files.f \
        && ./obj_dir_be${be}/Vtb_axi4s_trunc) || status=1
    echo "${out}"
    echo "${out}" | grep -qx "TEST OK" || status=1
done

[ "${status}" -eq 0 ] && echo "Both byte orders passed" || {
    echo "Simulation failed"
    exit 1
}
